// File: sdrc_geom_pkg.sv
// --------------------
// Geometry, widths and SDRAM timing of the controller core.
// Imported by every RTL block, and by the testbench for its sizes.
// --------------------
`default_nettype none

package sdrc_geom_pkg;

   // Application port
   localparam int APP_DW = 32;              // Word width
   localparam int APP_BW = APP_DW / 8;      // Byte enables, active low

   // SDRAM data pins, 16-bit part
   localparam int SDR_DW = 16;
   localparam int SDR_BW = SDR_DW / 8;      // One dqm bit per byte lane

   // Word address split, row on top, then bank, then column
   localparam int COL_W  = 8;               // Word column, beat bit added on the pins
   localparam int BANK_W = 2;
   localparam int ROW_W  = 13;
   localparam int APP_AW = ROW_W + BANK_W + COL_W;
   localparam int LEN_W  = 9;               // Request length in words
   localparam int SDR_AW = 13;              // Address pins

   localparam int ROW_WORDS = 1 << COL_W;   // Words in one open page

   // --------------------
   // Timing, in clk cycles
   localparam int T_RP    = 2;  // PRECHARGE to ACTIVE
   localparam int T_RCD   = 2;  // ACTIVE to READ/WRITE
   localparam int T_WR    = 2;  // Last write beat to PRECHARGE
   localparam int CAS_LAT = 2;  // READ to first beat on the pins
   localparam int CNT_W   = 3;  // Wait counter, holds the longest wait (CAS_LAT+2)

endpackage

`default_nettype wire

// File: sdrc_bus_pkg.sv
// --------------------
// Command encodings, FSM states and the structs passed between blocks.
// --------------------
`default_nettype none

package sdrc_bus_pkg;

   // SDRAM command, bits are {cs_n, ras_n, cas_n, we_n}
   typedef enum logic [3:0] {
      CMD_NOP       = 4'b0111,
      CMD_ACTIVE    = 4'b0011,
      CMD_READ      = 4'b0101,
      CMD_WRITE     = 4'b0100,
      CMD_PRECHARGE = 4'b0010
   } sdr_cmd_e;

   // Sequencer states
   typedef enum logic [2:0] {
      XS_IDLE,        // Waiting for a chunk
      XS_PRE_WAIT,    // PRECHARGE out, counting T_RP
      XS_ACT_WAIT,    // ACTIVE out, counting T_RCD
      XS_XFER,        // One READ/WRITE every other cycle
      XS_WR_RECOVER   // Write recovery or read drain after the last word
   } xfr_state_e;

   // Request as held on the application port
   typedef struct packed {
      logic [sdrc_geom_pkg::APP_AW-1:0] addr;  // Word address
      logic [sdrc_geom_pkg::LEN_W-1:0]  len;   // Words, at least one
      logic                             write;
   } app_req_t;

   // Piece of a request that stays inside one row
   typedef struct packed {
      logic [sdrc_geom_pkg::BANK_W-1:0] bank;
      logic [sdrc_geom_pkg::ROW_W-1:0]  row;
      logic [sdrc_geom_pkg::COL_W-1:0]  col;   // First word column
      logic [sdrc_geom_pkg::LEN_W-1:0]  len;
      logic                             write;
      logic                             last;  // Final chunk of its request
   } chunk_t;

   // Control pins
   typedef struct packed {
      sdr_cmd_e                         cmd;
      logic [sdrc_geom_pkg::BANK_W-1:0] ba;
      logic [sdrc_geom_pkg::SDR_AW-1:0] addr;
   } sdr_bus_t;

   // Data events, sequencer to width converter
   typedef struct packed {
      logic wr_beat;    // Write beat slot, one cycle ahead of the data pins
      logic rd_cmd;     // READ on the pins this cycle
      logic last_word;  // Final word of a request, with its first event
   } xfr_evt_t;

endpackage

`default_nettype wire

// File: sdrc_req_gen.sv
// --------------------
// Request intake. Takes one application request at a time and hands
// it to the sequencer as chunks that never cross a row end.
// --------------------
`default_nettype none

module sdrc_req_gen (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          app_req,
   input  wire sdrc_bus_pkg::app_req_t  app_req_info,
   output logic                         app_req_ack,
   output logic                         chunk_vld,
   output sdrc_bus_pkg::chunk_t         chunk,
   input  wire                          chunk_ack
);
   import sdrc_geom_pkg::*;
   import sdrc_bus_pkg::*;

   logic              busy;      // Request latched, chunks pending
   logic [APP_AW-1:0] cur_addr;  // Next word to hand out
   logic [LEN_W-1:0]  rem_len;   // Words still to hand out
   logic              cur_write;
   logic [LEN_W-1:0]  room;      // Words left in the current row
   logic              fits;

   // --------------------
   // Chunk decode
   always_comb begin
      room  = LEN_W'(ROW_WORDS) - LEN_W'(cur_addr[COL_W-1:0]);
      fits  = (rem_len <= room);  // Rest of request ends in this row
      chunk.bank  = cur_addr[COL_W +: BANK_W];
      chunk.row   = cur_addr[COL_W + BANK_W +: ROW_W];
      chunk.col   = cur_addr[COL_W-1:0];
      chunk.len   = fits ? rem_len : room;
      chunk.write = cur_write;
      chunk.last  = fits;
   end

   assign chunk_vld = busy;  // Level until the sequencer acks

   always_ff @(posedge clk) begin
      if (reset) begin
         busy        <= 1'b0;
         app_req_ack <= 1'b0;
      end else begin
         app_req_ack <= 1'b0;
         if (app_req && !busy) begin
            busy        <= 1'b1;
            app_req_ack <= 1'b1;  // Ack on intake, data moves later
         end else if (chunk_ack && chunk.last) begin
            busy <= 1'b0;
         end
      end
   end

   // Address and length walk
   always_ff @(posedge clk) begin
      if (app_req && !busy) begin
         cur_addr  <= app_req_info.addr;
         rem_len   <= app_req_info.len;
         cur_write <= app_req_info.write;
      end else if (chunk_ack) begin
         cur_addr <= cur_addr + APP_AW'(chunk.len);  // Lands on next row start
         rem_len  <= rem_len - chunk.len;
      end
   end

   // Chunk held steady for the sequencer until taken
   a_chunk_stable: assert property (@(posedge clk) disable iff (reset)
      chunk_vld && !chunk_ack |=> chunk_vld && $stable(chunk));

endmodule

`default_nettype wire

// File: sdrc_xfr_ctl.sv
// --------------------
// Open-page sequencer. Tracks the open row per bank, issues
// PRECHARGE/ACTIVE on a miss and one READ/WRITE per word.
// --------------------
`default_nettype none

module sdrc_xfr_ctl (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        chunk_vld,
   input  wire sdrc_bus_pkg::chunk_t  chunk,
   output logic                       chunk_ack,
   output sdrc_bus_pkg::sdr_bus_t     sdr_bus,
   output sdrc_bus_pkg::xfr_evt_t     evt
);
   import sdrc_geom_pkg::*;
   import sdrc_bus_pkg::*;

   xfr_state_e                         state;
   logic [CNT_W-1:0]                   cnt;       // Shared T_RP/T_RCD/T_WR wait
   chunk_t                             cur;       // Chunk in progress
   chunk_t                             src;       // New chunk in idle, else cur
   sdr_bus_t                           bus_a;     // Issue stage, pins follow a cycle later
   logic                               last_a;    // Final word, with bus_a
   logic                               last_q;    // Final word, with sdr_bus
   logic [(1<<BANK_W)-1:0]             open_vld;
   logic [(1<<BANK_W)-1:0][ROW_W-1:0]  open_row;
   logic                               hit;
   logic                               pre_go;
   logic                               act_go;
   logic                               word_go;

   // --------------------
   // Issue decisions
   always_comb begin
      src     = (state == XS_IDLE) ? chunk : cur;
      hit     = open_vld[src.bank] && (open_row[src.bank] == src.row);
      pre_go  = (state == XS_IDLE) && chunk_vld && !hit && open_vld[src.bank];
      act_go  = ((state == XS_IDLE) && chunk_vld && !open_vld[src.bank])
             || ((state == XS_PRE_WAIT) && (cnt == '0));
      word_go = ((state == XS_IDLE) && chunk_vld && hit)
             || ((state inside {XS_ACT_WAIT, XS_XFER}) && (cnt == '0));
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= XS_IDLE;
         cnt       <= '0;
         chunk_ack <= 1'b0;
         last_a    <= 1'b0;
         last_q    <= 1'b0;
         open_vld  <= '0;                          // All banks closed
         bus_a     <= '{cmd: CMD_NOP, default: '0};
         sdr_bus   <= '{cmd: CMD_NOP, default: '0};
      end else begin
         chunk_ack <= (state == XS_IDLE) && chunk_vld;  // With its first command
         bus_a.cmd <= CMD_NOP;
         last_a    <= 1'b0;
         sdr_bus   <= bus_a;                      // Pin register
         last_q    <= last_a;
         if (cnt != '0)
            cnt <= cnt - 1'b1;
         if (pre_go) begin                        // Other row open, close it
            bus_a              <= '{cmd: CMD_PRECHARGE, ba: src.bank, addr: '0};
            open_vld[src.bank] <= 1'b0;
            state              <= XS_PRE_WAIT;
            cnt                <= CNT_W'(T_RP - 1);
         end
         if (act_go) begin
            bus_a              <= '{cmd: CMD_ACTIVE, ba: src.bank, addr: SDR_AW'(src.row)};
            open_vld[src.bank] <= 1'b1;
            state              <= XS_ACT_WAIT;
            cnt                <= CNT_W'(T_RCD - 1);
         end
         if (word_go) begin
            bus_a.cmd  <= src.write ? CMD_WRITE : CMD_READ;
            bus_a.ba   <= src.bank;
            bus_a.addr <= SDR_AW'({src.col, 1'b0});  // BL2, A10 low
            last_a     <= src.last && (src.len == LEN_W'(1));
            if (src.len == LEN_W'(1)) begin
               state <= XS_WR_RECOVER;
               // Writes wait for T_WR, reads drain before the bus turns
               cnt   <= src.write ? CNT_W'(T_WR - 1) : CNT_W'(CAS_LAT + 2);
            end else begin
               state <= XS_XFER;
               cnt   <= CNT_W'(1);                 // Next word two cycles on
            end
         end
         if ((state == XS_WR_RECOVER) && (cnt == '0))
            state <= XS_IDLE;
      end
   end

   // Chunk copy and row table
   always_ff @(posedge clk) begin
      if ((state == XS_IDLE) && chunk_vld)
         cur <= chunk;
      if (word_go) begin
         cur.col <= src.col + 1'b1;
         cur.len <= src.len - 1'b1;
      end
      if (act_go)
         open_row[src.bank] <= src.row;
   end

   // --------------------
   // Events for the width converter
   always_comb begin
      evt.wr_beat   = (bus_a.cmd == CMD_WRITE) || (sdr_bus.cmd == CMD_WRITE);
      evt.rd_cmd    = (sdr_bus.cmd == CMD_READ);
      evt.last_word = (bus_a.cmd == CMD_WRITE) ? last_a
                    : ((sdr_bus.cmd == CMD_READ) && last_q);
   end

   // Column access only to the row activated earlier in that bank
   a_rw_open_row: assert property (@(posedge clk) disable iff (reset)
      (sdr_bus.cmd inside {CMD_READ, CMD_WRITE}) |->
         open_vld[sdr_bus.ba] && (open_row[sdr_bus.ba] == cur.row));

endmodule

`default_nettype wire

// File: sdrc_bus_conv.sv
// --------------------
// Width conversion. Splits 32-bit write words into two beats and packs
// read beats back into words, with the application data strobes.
// --------------------
`default_nettype none

module sdrc_bus_conv (
   input  wire                                clk,
   input  wire                                reset,
   input  wire sdrc_bus_pkg::xfr_evt_t        evt,
   input  wire [sdrc_geom_pkg::APP_DW-1:0]    app_wr_data,
   input  wire [sdrc_geom_pkg::APP_BW-1:0]    app_wr_en_n,
   output logic                               app_wr_next_req,
   output logic                               app_last_wr,
   output logic [sdrc_geom_pkg::APP_DW-1:0]   app_rd_data,
   output logic                               app_rd_valid,
   output logic                               app_last_rd,
   input  wire [sdrc_geom_pkg::SDR_DW-1:0]    sdr_din,
   output logic [sdrc_geom_pkg::SDR_DW-1:0]   sdr_dout,
   output logic [sdrc_geom_pkg::SDR_BW-1:0]   sdr_den_n,
   output logic [sdrc_geom_pkg::SDR_BW-1:0]   sdr_dqm
);
   import sdrc_geom_pkg::*;

   logic [SDR_DW-1:0]    din_q;    // Input register
   logic [SDR_DW-1:0]    rd_lo;    // First beat of a read word
   logic [CAS_LAT+1:0]   rd_sh;    // READ timing shift
   logic [CAS_LAT+1:0]   lst_sh;   // Last-word marker, same timing
   logic                 hi_phase; // High beat of a write word next
   logic [SDR_DW-1:0]    wr_hi;
   logic [SDR_BW-1:0]    wr_hi_m;

   // --------------------
   // Write side
   assign app_wr_next_req = evt.wr_beat && !hi_phase;  // Cycle before WRITE
   assign app_last_wr     = app_wr_next_req && evt.last_word;

   always_ff @(posedge clk) begin
      if (reset) begin
         hi_phase  <= 1'b0;
         sdr_den_n <= '1;
         sdr_dqm   <= '0;
      end else begin
         hi_phase <= evt.wr_beat && !hi_phase;
         if (app_wr_next_req) begin
            sdr_den_n <= '0;
            sdr_dqm   <= app_wr_en_n[SDR_BW-1:0];  // Low bytes with WRITE
         end else if (hi_phase) begin
            sdr_den_n <= '0;
            sdr_dqm   <= wr_hi_m;
         end else begin
            sdr_den_n <= '1;
            sdr_dqm   <= '0;   // Reads unmasked
         end
      end
   end

   always_ff @(posedge clk) begin
      if (app_wr_next_req) begin
         sdr_dout <= app_wr_data[SDR_DW-1:0];
         wr_hi    <= app_wr_data[APP_DW-1:SDR_DW];
         wr_hi_m  <= app_wr_en_n[APP_BW-1:SDR_BW];
      end else if (hi_phase) begin
         sdr_dout <= wr_hi;
      end
   end

   // --------------------
   // Read side
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_sh        <= '0;
         lst_sh       <= '0;
         app_rd_valid <= 1'b0;
         app_last_rd  <= 1'b0;
      end else begin
         rd_sh        <= {rd_sh[CAS_LAT:0], evt.rd_cmd};
         lst_sh       <= {lst_sh[CAS_LAT:0], evt.rd_cmd && evt.last_word};
         app_rd_valid <= rd_sh[CAS_LAT+1];  // Second beat in din_q
         app_last_rd  <= lst_sh[CAS_LAT+1];
      end
   end

   always_ff @(posedge clk) begin
      din_q <= sdr_din;
      if (rd_sh[CAS_LAT])
         rd_lo <= din_q;                     // Low half first
      if (rd_sh[CAS_LAT+1])
         app_rd_data <= {din_q, rd_lo};
   end

   // Read words and write beats never share a cycle
   a_rd_vs_wr: assert property (@(posedge clk) disable iff (reset)
      app_rd_valid |-> (&sdr_den_n));

endmodule

`default_nettype wire

// File: sdrc_core.sv
// --------------------
// Controller top. Wires intake, sequencer and width converter together.
// --------------------
`default_nettype none

module sdrc_core (
   input  wire                                clk,
   input  wire                                reset,
   // Application request
   input  wire                                app_req,
   input  wire sdrc_bus_pkg::app_req_t        app_req_info,
   output logic                               app_req_ack,
   // Application data
   input  wire [sdrc_geom_pkg::APP_DW-1:0]    app_wr_data,
   input  wire [sdrc_geom_pkg::APP_BW-1:0]    app_wr_en_n,
   output logic                               app_wr_next_req,
   output logic                               app_last_wr,
   output logic [sdrc_geom_pkg::APP_DW-1:0]   app_rd_data,
   output logic                               app_rd_valid,
   output logic                               app_last_rd,
   // SDRAM pins
   output logic                               sdr_cke,
   output sdrc_bus_pkg::sdr_bus_t             sdr_bus,
   output logic [sdrc_geom_pkg::SDR_BW-1:0]   sdr_dqm,
   output logic [sdrc_geom_pkg::SDR_DW-1:0]   sdr_dout,
   output logic [sdrc_geom_pkg::SDR_BW-1:0]   sdr_den_n,
   input  wire [sdrc_geom_pkg::SDR_DW-1:0]    sdr_din
);
   import sdrc_bus_pkg::*;

   logic     chunk_vld;
   logic     chunk_ack;
   chunk_t   chunk;
   xfr_evt_t evt;

   assign sdr_cke = 1'b1;  // No power-down, part assumed configured

   sdrc_req_gen u_req_gen (
      .clk          (clk),
      .reset        (reset),
      .app_req      (app_req),
      .app_req_info (app_req_info),
      .app_req_ack  (app_req_ack),
      .chunk_vld    (chunk_vld),
      .chunk        (chunk),
      .chunk_ack    (chunk_ack)
   );

   sdrc_xfr_ctl u_xfr_ctl (
      .clk       (clk),
      .reset     (reset),
      .chunk_vld (chunk_vld),
      .chunk     (chunk),
      .chunk_ack (chunk_ack),
      .sdr_bus   (sdr_bus),
      .evt       (evt)
   );

   sdrc_bus_conv u_bus_conv (
      .clk             (clk),
      .reset           (reset),
      .evt             (evt),
      .app_wr_data     (app_wr_data),
      .app_wr_en_n     (app_wr_en_n),
      .app_wr_next_req (app_wr_next_req),
      .app_last_wr     (app_last_wr),
      .app_rd_data     (app_rd_data),
      .app_rd_valid    (app_rd_valid),
      .app_last_rd     (app_last_rd),
      .sdr_din         (sdr_din),
      .sdr_dout        (sdr_dout),
      .sdr_den_n       (sdr_den_n),
      .sdr_dqm         (sdr_dqm)
   );

endmodule

`default_nettype wire

// File: tb_sdram_model.sv
// --------------------
// Behavioral SDRAM for the testbench. Decodes the command pins, stores
// masked write beats and returns read beats CAS_LAT cycles after READ.
// --------------------
`default_nettype none

module tb_sdram_model (
   input  wire                               clk,
   input  wire sdrc_bus_pkg::sdr_bus_t       sdr_bus,
   input  wire [sdrc_geom_pkg::SDR_DW-1:0]   sdr_dout,
   input  wire [sdrc_geom_pkg::SDR_BW-1:0]   sdr_dqm,
   output logic [sdrc_geom_pkg::SDR_DW-1:0]  sdr_din
);
   timeunit 1ns;
   timeprecision 100ps;
   import sdrc_geom_pkg::*;
   import sdrc_bus_pkg::*;

   logic [SDR_DW-1:0] mem [bit [23:0]];   // Sparse, key {bank, row, beat column}
   logic [SDR_DW-1:0] due [int];          // Read beats by edge number
   logic [ROW_W-1:0]  open_row [4];
   int                edge_cnt = 0;
   bit                wr_pend = 1'b0;     // Second beat of a write next edge
   bit   [23:0]       wr_key;
   bit   [23:0]       key;

   initial sdr_din = '0;

   // Unwritten locations answer with a pattern of the whole address
   function automatic logic [SDR_DW-1:0] fetch(bit [23:0] k);
      if (mem.exists(k))
         return mem[k];
      return k[15:0] ^ {k[23:16], k[7:0]};
   endfunction

   task automatic store(bit [23:0] k, logic [SDR_DW-1:0] d, logic [SDR_BW-1:0] m);
      logic [SDR_DW-1:0] old;
      old    = fetch(k);
      mem[k] = {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};  // dqm high keeps
   endtask

   always @(posedge clk) begin
      edge_cnt = edge_cnt + 1;
      if (due.exists(edge_cnt)) begin
         sdr_din <= due[edge_cnt];
         due.delete(edge_cnt);
      end
      if (wr_pend) begin
         store(wr_key, sdr_dout, sdr_dqm);   // High beat
         wr_pend = 1'b0;
      end
      key = {sdr_bus.ba, open_row[sdr_bus.ba], sdr_bus.addr[COL_W:0]};
      case (sdr_bus.cmd)
         CMD_ACTIVE: open_row[sdr_bus.ba] = sdr_bus.addr[ROW_W-1:0];
         CMD_WRITE: begin
            store(key, sdr_dout, sdr_dqm);   // Low beat comes with the command
            wr_pend = 1'b1;
            wr_key  = key + 1;
         end
         CMD_READ: begin
            due[edge_cnt + CAS_LAT - 1] = fetch(key);
            due[edge_cnt + CAS_LAT]     = fetch(key + 1);
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: tb_sdrc.sv
// --------------------
// Testbench top. Plays the golden file through the controller and the
// SDRAM model, checks data, strobes and command counts and timing.
// --------------------
`default_nettype none

module tb_sdrc;
   timeunit 1ns;
   timeprecision 100ps;
   import sdrc_geom_pkg::*;
   import sdrc_bus_pkg::*;

   localparam bit [31:0] SEED   = 32'h2e99d8a5;
   localparam string     GOLDEN = "sdrc_golden.txt";

   logic              clk = 1'b0;
   logic              reset;
   logic              app_req;
   app_req_t          app_req_info;
   logic              app_req_ack;
   logic [APP_DW-1:0] app_wr_data;
   logic [APP_BW-1:0] app_wr_en_n;
   logic              app_wr_next_req;
   logic              app_last_wr;
   logic [APP_DW-1:0] app_rd_data;
   logic              app_rd_valid;
   logic              app_last_rd;
   logic              sdr_cke;
   sdr_bus_t          sdr_bus;
   logic [SDR_BW-1:0] sdr_dqm;
   logic [SDR_DW-1:0] sdr_dout;
   logic [SDR_BW-1:0] sdr_den_n;
   logic [SDR_DW-1:0] sdr_din;

   // Golden file contents, one entry per request
   string       t_name[$];
   bit          t_write[$];
   int          t_addr[$];
   int          t_len[$];
   int          t_act[$];
   int          t_pre[$];
   int          t_first[$];   // Index of its first data line
   logic [31:0] g_word[$];
   logic [3:0]  g_mask[$];
   int          total_words = 0;
   bit          loaded = 1'b0;

   int errs = 0;
   int gap_errs = 0;           // Written only by the command monitor
   int act_total = 0;
   int pre_total = 0;
   int cyc = 0;
   int last_pre[4] = '{default: -100};
   int last_act[4] = '{default: -100};
   int seed_val;
   bit                hi_beat = 1'b0;   // High write beat on the pins this cycle
   logic [SDR_BW-1:0] den_exp;

   always #2 clk = ~clk;       // 4 ns period

   sdrc_core sdrc_core_inst (.*);

   tb_sdram_model sdram (
      .clk      (clk),
      .sdr_bus  (sdr_bus),
      .sdr_dout (sdr_dout),
      .sdr_dqm  (sdr_dqm),
      .sdr_din  (sdr_din)
   );

   task automatic report_val(string sig, logic [31:0] got, logic [31:0] exp);
      $display("** Error at %0t: %s is %0h, expected %0h", $time, sig, got, exp);
      errs++;
   endtask

   task automatic gap_fail(string msg);
      $display("Timing error at %0t: %s", $time, msg);
      gap_errs <= gap_errs + 1;
   endtask

   task automatic load_golden();
      int          fd;
      int          n;
      int          addr;
      int          len;
      int          act;
      int          pre;
      string       line;
      string       name;
      string       op;
      logic [31:0] w;
      logic [3:0]  m;
      fd = $fopen(GOLDEN, "r");
      if (fd == 0) begin
         $display("Cannot open %s", GOLDEN);
         errs++;
      end else begin
         while ($fgets(line, fd)) begin
            if (line.len() < 2)
               continue;
            if (line.getc(0) == "T") begin       // Request header
               n = $sscanf(line, "T %s %s %h %d %d %d", name, op, addr, len, act, pre);
               assert (n == 6)
                  else begin
                     $display("Malformed request line in %s", GOLDEN);
                     errs++;
                  end
               t_name.push_back(name);
               t_write.push_back(op == "W");
               t_addr.push_back(addr);
               t_len.push_back(len);
               t_act.push_back(act);
               t_pre.push_back(pre);
               t_first.push_back(g_word.size());
               total_words += len;
            end else if (line.getc(0) == "D") begin
               n = $sscanf(line, "D %h %h", w, m);
               assert (n == 2)
                  else begin
                     $display("Malformed data line in %s", GOLDEN);
                     errs++;
                  end
               g_word.push_back(w);
               g_mask.push_back(m);
            end
         end
         $fclose(fd);
      end
   endtask

   // --------------------
   // One request, from app_req to its last data word
   task automatic run_test(int t);
      int widx;
      int ridx;
      int base;
      int len;
      int act0;
      int pre0;
      int err0;
      bit wr;
      bit done;
      len  = t_len[t];
      wr   = t_write[t];
      base = t_first[t];
      act0 = act_total;
      pre0 = pre_total;
      err0 = errs + gap_errs;
      widx = 0;
      ridx = 0;
      done = 1'b0;
      app_req      <= 1'b1;
      app_req_info <= '{addr: APP_AW'(t_addr[t]), len: LEN_W'(len), write: wr};
      app_wr_data  <= g_word[base];
      app_wr_en_n  <= g_mask[base];
      while (!done) begin
         @(posedge clk);
         if (app_req_ack)
            app_req <= 1'b0;
         if (wr && app_wr_next_req) begin      // Word taken at this edge
            assert (app_last_wr == (widx == len - 1))
               else report_val("app_last_wr", app_last_wr, widx == len - 1);
            widx++;
            if (widx < len) begin
               app_wr_data <= g_word[base + widx];
               app_wr_en_n <= g_mask[base + widx];
            end else begin
               done = 1'b1;
            end
         end
         if (!wr && app_rd_valid) begin
            assert (app_rd_data == g_word[base + ridx])
               else report_val("app_rd_data", app_rd_data, g_word[base + ridx]);
            assert (app_last_rd == (ridx == len - 1))
               else report_val("app_last_rd", app_last_rd, ridx == len - 1);
            ridx++;
            done = (ridx == len);
         end
      end
      assert (act_total - act0 == t_act[t])
         else report_val("ACTIVE count", act_total - act0, t_act[t]);
      assert (pre_total - pre0 == t_pre[t])
         else report_val("PRECHARGE count", pre_total - pre0, t_pre[t]);
      $display("%-10s %s", t_name[t], (errs + gap_errs == err0) ? "ok" : "FAILED");
   endtask

   // --------------------
   // Command monitor, counts and minimum gaps
   always @(posedge clk) begin
      cyc = cyc + 1;
      if (!reset) begin
         // Data pins driven only for the two beats of each WRITE
         den_exp = ((sdr_bus.cmd == CMD_WRITE) || hi_beat) ? '0 : '1;
         assert (sdr_den_n == den_exp)
            else report_val("sdr_den_n", sdr_den_n, den_exp);
         hi_beat = (sdr_bus.cmd == CMD_WRITE);
         case (sdr_bus.cmd)
            CMD_PRECHARGE: begin
               pre_total <= pre_total + 1;
               last_pre[sdr_bus.ba] = cyc;
            end
            CMD_ACTIVE: begin
               assert (cyc - last_pre[sdr_bus.ba] >= T_RP)
                  else gap_fail("ACTIVE issued before T_RP elapsed");
               act_total <= act_total + 1;
               last_act[sdr_bus.ba] = cyc;
            end
            CMD_READ, CMD_WRITE: begin
               assert (last_act[sdr_bus.ba] > last_pre[sdr_bus.ba])
                  else gap_fail("READ or WRITE to a bank with no open row");
               assert (cyc - last_act[sdr_bus.ba] >= T_RCD)
                  else gap_fail("READ or WRITE issued before T_RCD elapsed");
            end
            default: ;
         endcase
      end
   end

   initial begin
      reset        = 1'b1;
      app_req      = 1'b0;
      app_req_info = '0;
      app_wr_data  = '0;
      app_wr_en_n  = '1;
      seed_val     = $urandom(SEED);
      load_golden();
      loaded = 1'b1;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      assert (!app_req_ack && !app_wr_next_req && !app_last_wr && !app_rd_valid
              && !app_last_rd && sdr_bus.cmd == CMD_NOP && (&sdr_den_n) && sdr_cke)
         else begin
            $display("Outputs not idle after reset");
            errs++;
         end
      foreach (t_name[t]) begin
         repeat ($urandom_range(1, 8)) @(posedge clk);   // Idle gap
         run_test(t);
      end
      repeat (20) @(posedge clk);
      $display("Tests: %0d  errors: %0d", t_name.size(), errs + gap_errs);
      if (errs + gap_errs == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // Watchdog, 40 cycles per word in the file plus a margin
   initial begin
      wait (loaded);
      repeat (total_words * 40 + 500) @(posedge clk);
      $display("Timeout, the tests did not finish in time");
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sdrc_golden.txt
# T name op(W or R) word_addr(hex) len_words expected_active expected_precharge
# D word(hex) byte_enable_n(hex); read lines hold the expected word and mask 0
T wr4 W 000010 4 1 0
D 01234567 0
D 89abcdef 0
D 0badf00d 0
D 13572468 0
T rd4 R 000010 4 0 0
D 01234567 0
D 89abcdef 0
D 0badf00d 0
D 13572468 0
T split_wr W 0001fe 6 2 0
D a5a5a5a5 0
D 5a5a5a5a 0
D 00ff00ff 0
D ff00ff00 0
D 12345678 0
D 87654321 0
T split_rd R 0001fe 6 0 0
D a5a5a5a5 0
D 5a5a5a5a 0
D 00ff00ff 0
D ff00ff00 0
D 12345678 0
D 87654321 0
T hit_rd R 000012 2 0 0
D 0badf00d 0
D 13572468 0
T miss_wr W 000420 1 1 1
D cafef00d 0
T miss_rd R 000010 1 1 1
D 01234567 0
T mask_full W 000030 1 0 0
D 11223344 0
T mask_part W 000030 1 0 0
D aabbccdd 5
T mask_rd R 000030 1 0 0
D aa22cc44 0

// File: vlog.f
sdrc_geom_pkg.sv
sdrc_bus_pkg.sv
sdrc_req_gen.sv
sdrc_xfr_ctl.sv
sdrc_bus_conv.sv
sdrc_core.sv
tb_sdram_model.sv
tb_sdrc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sdrc
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
